// File: byteRam.sv
module byteRam #(
    parameter int ramAddrWidth = 12
) (
    input  logic                    clk,
    input  logic [ramAddrWidth-1:0] addr,
    input  logic                    we,
    input  memPkg::byteT            wdata,
    output memPkg::byteT            rdata
);
    import memPkg::*;

    localparam int ramSize = 2 ** ramAddrWidth;

    byteT mem [ramSize];

    // known pattern so fetches and loads can be checked from power-up
    initial begin
        for (int i = 0; i < ramSize; i++) begin
            mem[i] = byteT'(i * 7 + 3);
        end
    end

    // read returns the old byte on a write to the same address
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

// File: files.f
memPkg.sv
byteRam.sv
instQueue.sv
instFetch.sv
memCtrl.sv
memSubsys.sv
memChecker.sv
tbMemSubsys.sv

// File: instFetch.sv
module instFetch #(
    parameter memPkg::addrT resetPc    = '0,
    parameter int           queueDepth = 4
) (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        redirect,
    input  memPkg::addrT                redirectPc,

    output logic                        fetchEn,
    output memPkg::addrT                fetchAddr,
    input  logic                        fetchDone,
    input  memPkg::wordT                fetchInst,

    output logic                        pushEn,
    output memPkg::fetchEntryT          pushEntry,
    output logic                        flush,
    input  logic [$clog2(queueDepth):0] queueFree
);
    import memPkg::*;

    localparam int freeWidth = $clog2(queueDepth) + 1;

    addrT                 pc;
    logic [freeWidth-1:0] inFlight;

    // a word finishing this cycle takes a slot the count does not show yet
    assign inFlight = {{(freeWidth-1){1'b0}}, pushEn};

    // low for the redirect cycle so the controller drops the old fetch
    assign fetchEn   = !redirect && (queueFree > inFlight);
    assign fetchAddr = pc;

    // a word landing during a redirect belongs to the old stream
    assign pushEn = fetchDone && !redirect;
    assign flush  = redirect;

    always_comb begin
        pushEntry.pc   = pc;
        pushEntry.inst = fetchInst;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= resetPc;
        end else if (redirect) begin
            pc <= redirectPc;
        end else if (pushEn) begin
            pc <= pc + pcStep;
        end
    end

endmodule

// File: instQueue.sv
module instQueue #(
    parameter type entryT     = logic [63:0],
    parameter int  queueDepth = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        push,
    input  entryT                       pushEntry,
    input  logic                        pop,
    input  logic                        flush,
    output logic                        valid,
    output entryT                       headEntry,
    output logic [$clog2(queueDepth):0] freeCount
);
    localparam int ptrWidth = $clog2(queueDepth);
    localparam int cntWidth = ptrWidth + 1;

    entryT                slots [queueDepth];
    logic [ptrWidth-1:0]  rdPtr;
    logic [ptrWidth-1:0]  wrPtr;
    logic [cntWidth-1:0]  count;
    logic                 full;
    logic                 doPush;
    logic                 doPop;

    assign full      = count == cntWidth'(queueDepth);
    assign valid     = count != '0;
    assign headEntry = slots[rdPtr];
    assign freeCount = cntWidth'(queueDepth) - count;

    assign doPush = push && !full && !flush;
    assign doPop  = pop && valid;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            // pointers wrap naturally, depth is a power of two
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            slots[wrPtr] <= pushEntry;
        end
    end

endmodule

// File: memChecker.sv
module memChecker #(
    parameter int           ramAddrWidth = 12,
    parameter memPkg::addrT resetPc      = '0
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               ready,
    input  logic               dataEn,
    input  memPkg::dataReqT    dataReq,
    input  logic               dataDone,
    input  memPkg::wordT       dataRdata,
    input  logic               redirect,
    input  memPkg::addrT       redirectPc,
    input  logic               instPop,
    input  logic               instValid,
    input  memPkg::fetchEntryT instOut,
    input  memPkg::byteT       shadow [2**ramAddrWidth],
    output int                 errorCount,
    output int                 loadCount,
    output int                 popCount
);
    import memPkg::*;

    int   errors = 0;
    int   loads  = 0;
    int   pops   = 0;
    addrT expectPc;
    logic doneLast;
    wordT expWord;

    assign errorCount = errors;
    assign loadCount  = loads;
    assign popCount   = pops;

    // little-endian, bytes above nBytes stay zero
    function automatic wordT shadowWord(input addrT base, input int nBytes);
        wordT w;
        addrT a;
        w = '0;
        for (int i = 0; i < nBytes; i++) begin
            a = base + addrT'(i);
            w[8*i +: 8] = shadow[a[ramAddrWidth-1:0]];
        end
        return w;
    endfunction

    task automatic valueMismatch(input string name, input wordT got, input wordT want);
        errors++;
        $display("CHECK FAILED %s got %h expected %h at time %0t", name, got, want, $time);
    endtask

    task automatic protocolError(input string what);
        errors++;
        $display("protocol error at time %0t: %s", $time, what);
    endtask

    // sampled mid-cycle, away from the edge where the DUT and stimulus update
    always @(negedge clk) begin
        if (rst) begin
            expectPc = resetPc;
            doneLast = 1'b0;
            if (instValid !== 1'b0) begin
                valueMismatch("instValid", {31'b0, instValid}, '0);
            end
            if (dataDone !== 1'b0) begin
                valueMismatch("dataDone", {31'b0, dataDone}, '0);
            end
        end else begin
            if (dataDone) begin
                if (!ready) begin
                    protocolError("dataDone pulsed while ready was low");
                end
                if (!dataEn) begin
                    protocolError("dataDone pulsed with no request pending");
                end
                if (doneLast) begin
                    protocolError("dataDone stayed high for a second cycle");
                end
                if (dataReq.dir == accLoad) begin
                    loads++;
                    expWord = shadowWord(dataReq.addr, int'(dataReq.len));
                    if (dataRdata !== expWord) begin
                        valueMismatch("dataRdata", dataRdata, expWord);
                    end
                end
            end
            doneLast = dataDone;
            // redirect flushes the queue, a pop in that cycle takes nothing
            if (redirect) begin
                expectPc = redirectPc;
            end else if (instPop && instValid) begin
                pops++;
                if (instOut.pc !== expectPc) begin
                    valueMismatch("instOut.pc", instOut.pc, expectPc);
                end
                expWord = shadowWord(instOut.pc, 4);
                if (instOut.inst !== expWord) begin
                    valueMismatch("instOut.inst", instOut.inst, expWord);
                end
                // resync so a single slip is reported once
                expectPc = instOut.pc + pcStep;
            end
        end
    end

endmodule

// File: memCtrl.sv
module memCtrl #(
    parameter int ramAddrWidth = 12
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ready,

    input  logic                    fetchEn,
    input  memPkg::addrT            fetchAddr,
    output logic                    fetchDone,
    output memPkg::wordT            fetchInst,

    input  logic                    dataEn,
    input  memPkg::dataReqT         dataReq,
    output logic                    dataDone,
    output memPkg::wordT            dataRdata,

    output logic [ramAddrWidth-1:0] ramAddr,
    output logic                    ramWe,
    output memPkg::byteT            ramWdata,
    input  memPkg::byteT            ramRdata
);
    import memPkg::*;

    typedef enum logic [1:0] {
        ownNone,
        ownFetch,
        ownData
    } ownerE;

    ownerE                   owner;
    logic [2:0]              stage;
    logic [ramAddrWidth-1:0] lastAddr;
    wordT                    rdBuf;
    wordT                    assembled;

    logic       busy;
    logic       isStore;
    logic       writing;
    logic       reading;
    logic       lastStage;
    logic       finish;
    logic       accept;
    logic       abandon;
    logic       capture;
    logic [2:0] xferLen;
    logic [1:0] capIdx;
    addrT       baseAddr;
    addrT       curAddr;

    assign busy    = owner != ownNone;
    assign isStore = dataReq.dir == accStore;
    assign writing = (owner == ownData) && isStore;
    assign reading = busy && !writing;

    // fetches are always a full word
    assign xferLen  = (owner == ownFetch) ? 3'(lenWord) : 3'(dataReq.len);
    assign baseAddr = (owner == ownFetch) ? fetchAddr : dataReq.addr;
    assign curAddr  = baseAddr + addrT'(stage);

    // stores finish on the last write, reads one stage later
    // when the final byte sits on ramRdata
    assign lastStage = writing ? (stage == xferLen - 3'd1) : (stage == xferLen);
    assign finish    = busy && ready && lastStage;
    assign dataDone  = finish && (owner == ownData);
    assign fetchDone = finish && (owner == ownFetch);

    // idle arbitration, data side first
    assign accept  = ready && !busy && (dataEn || fetchEn);
    assign abandon = (owner == ownFetch) && !fetchEn;

    // byte read at stage-1 arrives now
    assign capture = ready && reading && (stage != 3'd0);
    assign capIdx  = 2'(stage - 3'd1);

    // repeat the last address while frozen or idle, so the
    // byte in flight is still on ramRdata when ready returns
    assign ramAddr  = (ready && busy) ? curAddr[ramAddrWidth-1:0] : lastAddr;
    assign ramWe    = ready && writing;
    assign ramWdata = dataReq.wdata[8*stage[1:0] +: 8];

    // little-endian assembly with the live byte merged in
    always_comb begin
        assembled = rdBuf;
        if (stage != 3'd0) begin
            assembled[8*capIdx +: 8] = ramRdata;
        end
    end

    assign fetchInst = assembled;
    assign dataRdata = assembled;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner    <= ownNone;
            stage    <= '0;
            lastAddr <= '0;
        end else begin
            lastAddr <= ramAddr;
            if (abandon) begin
                // fetcher gave up, drop the partial word
                owner <= ownNone;
                stage <= '0;
            end else if (accept) begin
                owner <= dataEn ? ownData : ownFetch;
                stage <= '0;
            end else if (ready && busy) begin
                if (lastStage) begin
                    owner <= ownNone;
                    stage <= '0;
                end else begin
                    stage <= stage + 3'd1;
                end
            end
        end
    end

    // cleared on accept so short loads come out zero-extended
    always_ff @(posedge clk) begin
        if (accept) begin
            rdBuf <= '0;
        end else if (capture) begin
            rdBuf[8*capIdx +: 8] <= ramRdata;
        end
    end

endmodule

// File: memPkg.sv
package memPkg;

    typedef logic [31:0] addrT;
    typedef logic [31:0] wordT;
    typedef logic [7:0]  byteT;

    // value is the byte count
    typedef enum logic [2:0] {
        lenByte = 3'd1,
        lenHalf = 3'd2,
        lenWord = 3'd4
    } accLenE;

    typedef enum logic {
        accLoad  = 1'b0,
        accStore = 1'b1
    } accDirE;

    // load/store request from the data side
    typedef struct packed {
        accDirE dir;
        accLenE len;
        addrT   addr;
        wordT   wdata;
    } dataReqT;

    // one fetched instruction and where it came from
    typedef struct packed {
        addrT pc;
        wordT inst;
    } fetchEntryT;

    localparam addrT pcStep = 32'd4;

endpackage

// File: memSubsys.sv
module memSubsys #(
    parameter int           ramAddrWidth = 12,
    parameter int           queueDepth   = 4,
    parameter memPkg::addrT resetPc      = '0
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               ready,

    input  logic               dataEn,
    input  memPkg::dataReqT    dataReq,
    output logic               dataDone,
    output memPkg::wordT       dataRdata,

    input  logic               redirect,
    input  memPkg::addrT       redirectPc,

    input  logic               instPop,
    output logic               instValid,
    output memPkg::fetchEntryT instOut
);
    import memPkg::*;

    logic                        fetchEn;
    addrT                        fetchAddr;
    logic                        fetchDone;
    wordT                        fetchInst;
    logic                        pushEn;
    fetchEntryT                  pushEntry;
    logic                        flush;
    logic [$clog2(queueDepth):0] queueFree;
    logic [ramAddrWidth-1:0]     ramAddr;
    logic                        ramWe;
    byteT                        ramWdata;
    byteT                        ramRdata;

    instFetch #(
        .resetPc   (resetPc),
        .queueDepth(queueDepth)
    ) instFetch_i (
        .clk       (clk),
        .rst       (rst),
        .redirect  (redirect),
        .redirectPc(redirectPc),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .pushEn    (pushEn),
        .pushEntry (pushEntry),
        .flush     (flush),
        .queueFree (queueFree)
    );

    instQueue #(
        .entryT    (fetchEntryT),
        .queueDepth(queueDepth)
    ) instQueue_i (
        .clk      (clk),
        .rst      (rst),
        .push     (pushEn),
        .pushEntry(pushEntry),
        .pop      (instPop),
        .flush    (flush),
        .valid    (instValid),
        .headEntry(instOut),
        .freeCount(queueFree)
    );

    memCtrl #(
        .ramAddrWidth(ramAddrWidth)
    ) memCtrl_i (
        .clk      (clk),
        .rst      (rst),
        .ready    (ready),
        .fetchEn  (fetchEn),
        .fetchAddr(fetchAddr),
        .fetchDone(fetchDone),
        .fetchInst(fetchInst),
        .dataEn   (dataEn),
        .dataReq  (dataReq),
        .dataDone (dataDone),
        .dataRdata(dataRdata),
        .ramAddr  (ramAddr),
        .ramWe    (ramWe),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

    byteRam #(
        .ramAddrWidth(ramAddrWidth)
    ) byteRam_i (
        .clk  (clk),
        .addr (ramAddr),
        .we   (ramWe),
        .wdata(ramWdata),
        .rdata(ramRdata)
    );

endmodule

// File: run.sh
#!/bin/bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -j 0 \
    --top-module tbMemSubsys -Mdir obj_dir -f files.f

./obj_dir/VtbMemSubsys | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// File: tbMemSubsys.sv
module tbMemSubsys;
    import memPkg::*;

    localparam int   ramAddrWidth   = 12;
    localparam int   queueDepth     = 4;
    localparam addrT resetPc        = 32'h0;
    localparam int   ramSize        = 2 ** ramAddrWidth;
    localparam int   clkPeriod      = 4;
    localparam int   resetCycles    = 16;
    localparam int   numReqs        = 200;
    localparam int   watchdogCycles = numReqs * 40 + 1000;

    logic       clk = 1'b0;
    logic       rst;
    logic       ready;
    logic       dataEn;
    dataReqT    dataReq;
    logic       dataDone;
    wordT       dataRdata;
    logic       redirect;
    addrT       redirectPc;
    logic       instPop;
    logic       instValid;
    fetchEntryT instOut;

    byteT        shadow [ramSize];
    logic [31:0] lfsr;
    int          errorCount;
    int          loadCount;
    int          popCount;

    always #(clkPeriod / 2) clk = ~clk;

    memSubsys #(
        .ramAddrWidth(ramAddrWidth),
        .queueDepth  (queueDepth),
        .resetPc     (resetPc)
    ) memSubsys_i (
        .clk       (clk),
        .rst       (rst),
        .ready     (ready),
        .dataEn    (dataEn),
        .dataReq   (dataReq),
        .dataDone  (dataDone),
        .dataRdata (dataRdata),
        .redirect  (redirect),
        .redirectPc(redirectPc),
        .instPop   (instPop),
        .instValid (instValid),
        .instOut   (instOut)
    );

    memChecker #(
        .ramAddrWidth(ramAddrWidth),
        .resetPc     (resetPc)
    ) memChecker_i (
        .clk       (clk),
        .rst       (rst),
        .ready     (ready),
        .dataEn    (dataEn),
        .dataReq   (dataReq),
        .dataDone  (dataDone),
        .dataRdata (dataRdata),
        .redirect  (redirect),
        .redirectPc(redirectPc),
        .instPop   (instPop),
        .instValid (instValid),
        .instOut   (instOut),
        .shadow    (shadow),
        .errorCount(errorCount),
        .loadCount (loadCount),
        .popCount  (popCount)
    );

    // taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsrNext(lfsr);
        end
        return r;
    endfunction

    function automatic dataReqT pickRequest();
        dataReqT     r;
        logic [31:0] lenSel;
        r.dir  = (takeBits(1) != 0) ? accStore : accLoad;
        lenSel = takeBits(2);
        case (lenSel)
            32'd0:   r.len = lenByte;
            32'd1:   r.len = lenHalf;
            default: r.len = lenWord;
        endcase
        // narrow window half the time so loads hit recent stores
        if (takeBits(1) != 0) begin
            r.addr = 32'h40 + takeBits(4);
        end else begin
            r.addr = takeBits(8);
        end
        r.wdata = takeBits(32);
        return r;
    endfunction

    function automatic void applyStore(input dataReqT r);
        addrT a;
        for (int i = 0; i < int'(r.len); i++) begin
            a = r.addr + addrT'(i);
            shadow[a[ramAddrWidth-1:0]] = r.wdata[8*i +: 8];
        end
    endfunction

    initial begin
        dataReqT req;
        logic    doneNow;
        logic    popNow;
        logic    reqOpen;
        logic    dataLive;
        int      cycle;
        int      redirectGap;
        int      gapLeft;
        int      completed;
        int      tailLeft;

        lfsr       = 32'h12adb22d;
        rst        = 1'b1;
        ready      = 1'b1;
        dataEn     = 1'b0;
        dataReq    = '0;
        redirect   = 1'b0;
        redirectPc = '0;
        instPop    = 1'b0;
        for (int i = 0; i < ramSize; i++) begin
            shadow[i] = byteT'(i * 7 + 3);
        end
        req         = '0;
        reqOpen     = 1'b0;
        dataLive    = 1'b0;
        cycle       = 0;
        gapLeft     = 0;
        completed   = 0;
        tailLeft    = 64;
        redirectGap = 24 + int'(takeBits(5));

        repeat (resetCycles) @(posedge clk);
        rst   <= 1'b0;
        ready <= 1'b1;

        while (tailLeft > 0) begin
            @(negedge clk);
            doneNow = dataDone;
            @(posedge clk);
            cycle++;
            ready <= takeBits(3) != 0;
            if (redirectGap == 0) begin
                redirect    <= 1'b1;
                redirectPc  <= 32'h800 + (takeBits(8) << 2);
                redirectGap = 24 + int'(takeBits(5));
                // stores begin once fetch has left the low region
                dataLive    = 1'b1;
                popNow      = 1'b0;
            end else begin
                redirect    <= 1'b0;
                redirectGap = redirectGap - 1;
                // pops held back for a stretch so the queue fills
                popNow = (cycle[7:6] == 2'b11) ? 1'b0 : (takeBits(1) != 0);
            end
            instPop <= popNow;

            if (reqOpen) begin
                if (doneNow) begin
                    if (req.dir == accStore) begin
                        applyStore(req);
                    end
                    dataEn    <= 1'b0;
                    reqOpen   = 1'b0;
                    completed = completed + 1;
                    gapLeft   = int'(takeBits(3));
                end
            end else if (dataLive && completed < numReqs) begin
                if (gapLeft == 0) begin
                    req     = pickRequest();
                    dataReq <= req;
                    dataEn  <= 1'b1;
                    reqOpen = 1'b1;
                end else begin
                    gapLeft = gapLeft - 1;
                end
            end else if (completed == numReqs) begin
                tailLeft = tailLeft - 1;
            end
        end

        if (loadCount == 0 || popCount == 0) begin
            $display("too little traffic: no loads or no popped instructions were checked");
        end
        $display("loads checked %0d, instructions popped %0d, errors %0d",
                 loadCount, popCount, errorCount);
        if (errorCount == 0 && loadCount > 0 && popCount > 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // 40 cycles a request is far above the worst arbitration wait
    initial begin
        #(watchdogCycles * clkPeriod);
        $display("watchdog: the run did not finish within %0d cycles", watchdogCycles);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule
